//--- src/ex_settings.svh
`ifndef EX_SETTINGS_SVH
`define EX_SETTINGS_SVH

// Execute stage build settings

// Data word width of the core
`define EX_XLEN 32

// Width of the ALU opcode field
`define EX_ALU_OP_W 4

// Iterations of the serial multiplier/divider
// One result bit per step
`define EX_MD_STEPS 32

`endif

//--- src/ex_pkg.sv
`include "ex_settings.svh"

package ex_pkg;

  // Plain data word
  typedef logic [`EX_XLEN-1:0] word_t;
  // Adder operand, word plus sign or carry bit
  typedef logic [`EX_XLEN:0]   adder_op_t;
  // Adder sum with room for the carry out
  typedef logic [`EX_XLEN+1:0] adder_ext_t;
  // Iteration counter of the multiplier/divider
  typedef logic [$clog2(`EX_MD_STEPS)-1:0] step_cnt_t;

  // ALU opcodes, branch compares included
  typedef enum logic [`EX_ALU_OP_W-1:0] {
    ADD, SUB, XOR, OR, AND, SLL, SRL, SRA,
    SLT, SLTU, EQ, NE, LT, GE, LTU, GEU
  } alu_op_e;

  // Multiply/divide opcodes
  typedef enum logic [1:0] {
    MD_MUL, MD_MULH, MD_DIV, MD_REM
  } md_op_e;

  // Sequencer states
  typedef enum logic [2:0] {
    MD_IDLE, MD_PREP, MD_ITER, MD_FIX, MD_DONE
  } md_state_e;

  // Per-cycle command to the multiply/divide registers
  typedef enum logic [2:0] {
    STEP_HOLD, STEP_LOAD, STEP_MUL, STEP_DIV, STEP_NEG_RES, STEP_KEEP
  } md_step_e;

  typedef struct packed {
    alu_op_e op;
    word_t   operand_a;
    word_t   operand_b;
  } alu_req_t;

  // signed_mode[0] marks a as signed, signed_mode[1] marks b as signed
  typedef struct packed {
    md_op_e     op;
    logic [1:0] signed_mode;
    word_t      operand_a;
    word_t      operand_b;
  } md_req_t;

  // Operands the multiplier/divider hands to the shared adder
  // use_md steers the adder away from the ALU request
  typedef struct packed {
    adder_op_t a;
    adder_op_t b;
    logic      use_md;
  } adder_in_t;

endpackage

//--- src/ex_alu.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_alu import ex_pkg::*; (
  // Request from decode
  input  alu_req_t   alu_req_i,
  // Borrowed adder operands from the multiplier/divider
  input  adder_in_t  md_adder_in_i,
  output word_t      adder_result_o,
  output adder_ext_t adder_ext_o,
  output word_t      result_o,
  output logic       cmp_result_o,
  output logic       is_equal_o
);

  localparam int SHAMT_W = $clog2(`EX_XLEN);

  alu_op_e           op;
  word_t             op_a;
  word_t             op_b;
  logic              sub_op;
  logic              signed_cmp;
  logic              carry_in;
  adder_op_t         add_a;
  adder_op_t         add_b;
  logic              less_than;
  logic              shift_left;
  word_t             a_rev;
  word_t             shift_rev;
  logic [`EX_XLEN:0] shift_in;
  logic [`EX_XLEN:0] shift_out;
  word_t             shift_result;
  word_t             logic_result;

  assign op   = alu_req_i.op;
  assign op_a = alu_req_i.operand_a;
  assign op_b = alu_req_i.operand_b;

  //////////////////////////////////////////////////////////////////////
  // Shared adder
  //////////////////////////////////////////////////////////////////////

  // Compares run as a subtraction
  assign sub_op     = op inside {SUB, SLT, SLTU, EQ, NE, LT, GE, LTU, GEU};
  assign signed_cmp = op inside {SLT, LT, GE};

  always_comb begin
    if (md_adder_in_i.use_md) begin
      // Multiplier/divider owns the adder, no carry in
      add_a    = md_adder_in_i.a;
      add_b    = md_adder_in_i.b;
      carry_in = 1'b0;
    end else begin
      // Extend to 33 bits so the difference sign is exact
      add_a = {signed_cmp & op_a[`EX_XLEN-1], op_a};
      add_b = {signed_cmp & op_b[`EX_XLEN-1], op_b};
      if (sub_op) begin
        add_b = ~add_b;
      end
      carry_in = sub_op;
    end
  end

  assign adder_ext_o    = adder_ext_t'(add_a) + adder_ext_t'(add_b) + adder_ext_t'(carry_in);
  assign adder_result_o = adder_ext_o[`EX_XLEN-1:0];

  // Zero 33-bit sum means equal operands, or a zero divisor during load
  assign is_equal_o = (adder_ext_o[`EX_XLEN:0] == '0);
  // Sign of the 33-bit difference
  assign less_than  = adder_ext_o[`EX_XLEN];

  //////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////

  // One right shifter, left shift done on the reversed word
  assign shift_left = (op == SLL);

  always_comb begin
    for (int i = 0; i < `EX_XLEN; i++) begin
      a_rev[i] = op_a[`EX_XLEN-1-i];
    end
  end

  always_comb begin
    for (int i = 0; i < `EX_XLEN; i++) begin
      shift_rev[i] = shift_out[`EX_XLEN-1-i];
    end
  end

  // Extra top bit carries the sign for SRA
  assign shift_in     = {(op == SRA) & op_a[`EX_XLEN-1], shift_left ? a_rev : op_a};
  assign shift_out    = $signed(shift_in) >>> op_b[SHAMT_W-1:0];
  assign shift_result = shift_left ? shift_rev : shift_out[`EX_XLEN-1:0];

  //////////////////////////////////////////////////////////////////////
  // Logic, compare and result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    unique case (op)
      XOR:     logic_result = op_a ^ op_b;
      OR:      logic_result = op_a | op_b;
      default: logic_result = op_a & op_b;
    endcase
  end

  always_comb begin
    unique case (op)
      EQ:                     cmp_result_o = is_equal_o;
      NE:                     cmp_result_o = ~is_equal_o;
      SLT, SLTU, LT, LTU:     cmp_result_o = less_than;
      GE, GEU:                cmp_result_o = ~less_than;
      default:                cmp_result_o = 1'b0;
    endcase
  end

  always_comb begin
    unique case (op)
      ADD, SUB:      result_o = adder_result_o;
      XOR, OR, AND:  result_o = logic_result;
      SLL, SRL, SRA: result_o = shift_result;
      // Set-less-than and branch compares give the flag in bit 0
      default:       result_o = word_t'(cmp_result_o);
    endcase
  end

endmodule

//--- src/ex_md_ctrl.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_md_ctrl import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  // Enables and LSU status from the pipeline
  input  logic       md_en_i,
  input  logic       lsu_en_i,
  input  logic       lsu_ready_i,
  input  md_req_t    md_req_i,
  // Status and results from the datapaths
  input  logic       div_by_zero_i,
  input  word_t      alu_result_i,
  input  word_t      md_result_i,
  // Commands to the multiply/divide registers
  output md_step_e   md_step_o,
  output logic [1:0] md_signs_o,
  // Write-back and stall
  output word_t      regfile_wdata_o,
  output logic       ex_ready_o
);

  md_state_e state_q;
  md_state_e state_d;
  step_cnt_t cnt_q;
  step_cnt_t cnt_d;
  logic      a_neg;
  logic      b_neg;
  logic      is_mul;
  logic      neg_res;
  logic      md_ready;

  //////////////////////////////////////////////////////////////////////
  // Sign rules
  //////////////////////////////////////////////////////////////////////

  // Request is held stable by decode, so signs come straight from it
  assign a_neg  = md_req_i.signed_mode[0] & md_req_i.operand_a[`EX_XLEN-1];
  assign b_neg  = md_req_i.signed_mode[1] & md_req_i.operand_b[`EX_XLEN-1];
  assign is_mul = md_req_i.op inside {MD_MUL, MD_MULH};

  // Bit 0 negates a, bit 1 negates b before iterating
  assign md_signs_o = {b_neg, a_neg};

  always_comb begin
    unique case (md_req_i.op)
      MD_MUL, MD_MULH: neg_res = a_neg ^ b_neg;
      // Quotient of a zero divisor stays all ones
      MD_DIV:          neg_res = (a_neg ^ b_neg) & ~div_by_zero_i;
      // Remainder follows the dividend
      default:         neg_res = a_neg;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d   = state_q;
    cnt_d     = cnt_q;
    md_step_o = STEP_HOLD;
    unique case (state_q)
      MD_IDLE: begin
        if (md_en_i) begin
          state_d = MD_PREP;
        end
      end
      MD_PREP: begin
        // Latch magnitudes and test for a zero divisor
        md_step_o = STEP_LOAD;
        cnt_d     = '0;
        state_d   = MD_ITER;
      end
      MD_ITER: begin
        if (div_by_zero_i) begin
          // Result already formed at load
          md_step_o = STEP_KEEP;
          state_d   = MD_FIX;
        end else begin
          md_step_o = is_mul ? STEP_MUL : STEP_DIV;
          cnt_d     = cnt_q + 1'b1;
          if (cnt_q == step_cnt_t'(`EX_MD_STEPS-1)) begin
            state_d = MD_FIX;
          end
        end
      end
      MD_FIX: begin
        md_step_o = neg_res ? STEP_NEG_RES : STEP_KEEP;
        state_d   = MD_DONE;
      end
      default: begin
        // Result valid for one cycle, decode samples ready here
        md_step_o = STEP_KEEP;
        state_d   = MD_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= MD_IDLE;
      cnt_q   <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
    end
  end

  assign md_ready = (state_q == MD_DONE);

  //////////////////////////////////////////////////////////////////////
  // Stall and write-back
  //////////////////////////////////////////////////////////////////////

  // Multiply/divide wins over load/store, ALU ops finish at once
  always_comb begin
    if (md_en_i) begin
      ex_ready_o = md_ready;
    end else if (lsu_en_i) begin
      ex_ready_o = lsu_ready_i;
    end else begin
      ex_ready_o = 1'b1;
    end
  end

  assign regfile_wdata_o = md_en_i ? md_result_i : alu_result_i;

endmodule

//--- src/ex_md_datapath.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_md_datapath import ex_pkg::*; (
  input  logic       clk,
  input  logic       rst_n_i,
  input  md_req_t    md_req_i,
  // Step command and operand signs from the sequencer
  input  md_step_e   md_step_i,
  input  logic [1:0] md_signs_i,
  // Shared adder results
  input  adder_ext_t adder_ext_i,
  input  logic       is_equal_i,
  output adder_in_t  md_adder_in_o,
  output word_t      md_result_o,
  output logic       div_by_zero_o
);

  // acc holds the high product or the partial remainder
  // sreg holds multiplier then low product, or dividend then quotient
  word_t     acc_q;
  word_t     sreg_q;
  adder_op_t opb_q;
  logic      dbz_q;
  word_t     a_mag;
  word_t     b_mag;
  logic      is_div;
  logic      res_in_sreg;
  logic      neg_carry;

  assign a_mag       = md_signs_i[0] ? -md_req_i.operand_a : md_req_i.operand_a;
  assign b_mag       = md_signs_i[1] ? -md_req_i.operand_b : md_req_i.operand_b;
  assign is_div      = md_req_i.op inside {MD_DIV, MD_REM};
  assign res_in_sreg = md_req_i.op inside {MD_MUL, MD_DIV};
  assign md_result_o = res_in_sreg ? sreg_q : acc_q;

  // MULH negates the 64-bit product, carry into the high word when low is zero
  assign neg_carry = (md_req_i.op == MD_MULH) ? (sreg_q == '0) : 1'b1;

  always_comb begin
    md_adder_in_o = '0;
    unique case (md_step_i)
      STEP_LOAD: begin
        // 0 + b, a zero sum flags the zero divisor
        md_adder_in_o.b      = {1'b0, md_req_i.operand_b};
        md_adder_in_o.use_md = 1'b1;
      end
      STEP_MUL: begin
        md_adder_in_o.a      = {1'b0, acc_q};
        md_adder_in_o.b      = sreg_q[0] ? opb_q : '0;
        md_adder_in_o.use_md = 1'b1;
      end
      STEP_DIV: begin
        // Shifted remainder plus the negated divisor
        md_adder_in_o.a      = {acc_q, sreg_q[`EX_XLEN-1]};
        md_adder_in_o.b      = opb_q;
        md_adder_in_o.use_md = 1'b1;
      end
      STEP_NEG_RES: begin
        md_adder_in_o.a      = {1'b0, ~md_result_o};
        md_adder_in_o.b      = adder_op_t'(neg_carry);
        md_adder_in_o.use_md = 1'b1;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    unique case (md_step_i)
      STEP_LOAD: begin
        opb_q <= is_div ? -{1'b0, b_mag} : {1'b0, b_mag};
        if (is_div && is_equal_i) begin
          // Quotient all ones, remainder the dividend magnitude
          acc_q  <= a_mag;
          sreg_q <= '1;
        end else begin
          acc_q  <= '0;
          sreg_q <= a_mag;
        end
      end
      STEP_MUL: begin
        acc_q  <= adder_ext_i[`EX_XLEN:1];
        sreg_q <= {adder_ext_i[0], sreg_q[`EX_XLEN-1:1]};
      end
      STEP_DIV: begin
        // Carry out set means the difference is not negative
        if (adder_ext_i[`EX_XLEN+1]) begin
          acc_q <= adder_ext_i[`EX_XLEN-1:0];
        end else begin
          acc_q <= {acc_q[`EX_XLEN-2:0], sreg_q[`EX_XLEN-1]};
        end
        sreg_q <= {sreg_q[`EX_XLEN-2:0], adder_ext_i[`EX_XLEN+1]};
      end
      STEP_NEG_RES: begin
        if (res_in_sreg) begin
          sreg_q <= adder_ext_i[`EX_XLEN-1:0];
        end else begin
          acc_q <= adder_ext_i[`EX_XLEN-1:0];
        end
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n_i) begin
    if (!rst_n_i) begin
      dbz_q <= 1'b0;
    end else if (md_step_i == STEP_LOAD) begin
      dbz_q <= is_div & is_equal_i;
    end
  end

  assign div_by_zero_o = dbz_q;

endmodule

//--- src/ex_block.sv
`timescale 1ns/1ps

module ex_block import ex_pkg::*; (
  input  logic     clk,
  input  logic     rst_n_i,
  // Requests and enables from decode
  input  alu_req_t alu_req_i,
  input  md_req_t  md_req_i,
  input  logic     md_en_i,
  input  logic     lsu_en_i,
  // LSU done level
  input  logic     lsu_ready_i,
  output word_t    alu_adder_result_o,
  output word_t    regfile_wdata_o,
  // Jump target and branch decision towards fetch
  output word_t    jump_target_o,
  output logic     branch_decision_o,
  // Stage can take new data
  output logic     ex_ready_o
);

  word_t      adder_result;
  adder_ext_t adder_ext;
  word_t      alu_result;
  logic       cmp_result;
  logic       is_equal;
  adder_in_t  md_adder_in;
  md_step_e   md_step;
  logic [1:0] md_signs;
  word_t      md_result;
  logic       div_by_zero;

  assign alu_adder_result_o = adder_result;
  assign jump_target_o      = adder_result;
  assign branch_decision_o  = cmp_result;

  ex_alu alu_i (
    .alu_req_i      ( alu_req_i    ),
    .md_adder_in_i  ( md_adder_in  ),
    .adder_result_o ( adder_result ),
    .adder_ext_o    ( adder_ext    ),
    .result_o       ( alu_result   ),
    .cmp_result_o   ( cmp_result   ),
    .is_equal_o     ( is_equal     )
  );

  ex_md_ctrl md_ctrl_i (
    .clk             ( clk             ),
    .rst_n_i         ( rst_n_i         ),
    .md_en_i         ( md_en_i         ),
    .lsu_en_i        ( lsu_en_i        ),
    .lsu_ready_i     ( lsu_ready_i     ),
    .md_req_i        ( md_req_i        ),
    .div_by_zero_i   ( div_by_zero     ),
    .alu_result_i    ( alu_result      ),
    .md_result_i     ( md_result       ),
    .md_step_o       ( md_step         ),
    .md_signs_o      ( md_signs        ),
    .regfile_wdata_o ( regfile_wdata_o ),
    .ex_ready_o      ( ex_ready_o      )
  );

  ex_md_datapath md_datapath_i (
    .clk           ( clk         ),
    .rst_n_i       ( rst_n_i     ),
    .md_req_i      ( md_req_i    ),
    .md_step_i     ( md_step     ),
    .md_signs_i    ( md_signs    ),
    .adder_ext_i   ( adder_ext   ),
    .is_equal_i    ( is_equal    ),
    .md_adder_in_o ( md_adder_in ),
    .md_result_o   ( md_result   ),
    .div_by_zero_o ( div_by_zero )
  );

endmodule

//--- testbench/ex_block_assertions.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_block_assertions (
  input logic clk,
  input logic rst_n_i,
  input logic md_en_i,
  input logic lsu_en_i,
  input logic lsu_ready_i,
  // Stage ready as seen at the DUT boundary
  input logic ex_ready_i
);

  // Ready must always resolve once out of reset
  assert property (@(posedge clk) disable iff (!rst_n_i) !$isunknown(ex_ready_i))
    else $error("ex_ready_o is unknown");

  // LSU path is a plain pass-through
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   lsu_en_i |-> (ex_ready_i == lsu_ready_i))
    else $error("ex_ready_o differs from lsu_ready_i while lsu_en_i is high");

  // Bounded multiply/divide latency
  assert property (@(posedge clk) disable iff (!rst_n_i)
                   md_en_i |-> ##[0:`EX_MD_STEPS+4] ex_ready_i)
    else $error("ex_ready_o did not follow md_en_i in time");

  // Decode never issues both units at once
  assert property (@(posedge clk) disable iff (!rst_n_i) !(md_en_i && lsu_en_i))
    else $error("md_en_i and lsu_en_i are high together");

endmodule

bind ex_block ex_block_assertions assertions_i (
  .clk         ( clk         ),
  .rst_n_i     ( rst_n_i     ),
  .md_en_i     ( md_en_i     ),
  .lsu_en_i    ( lsu_en_i    ),
  .lsu_ready_i ( lsu_ready_i ),
  .ex_ready_i  ( ex_ready_o  )
);

//--- testbench/ex_block_tb.sv
`timescale 1ns/1ps
`include "ex_settings.svh"

module ex_block_tb import ex_pkg::*; ();

  localparam int CLK_PERIOD  = 20;
  localparam int N_ALU       = 200;
  localparam int N_BR        = 100;
  localparam int N_MUL       = 320;
  localparam int N_DIV       = 180;
  localparam int N_LSU       = 100;
  localparam int N_REQ       = N_ALU + N_BR + N_MUL + N_DIV + N_LSU;
  // Counted from the first negedge after the request is driven
  localparam int MD_MAX_WAIT = `EX_MD_STEPS + 4;

  typedef enum {CHK_ALU, CHK_MD, CHK_LSU} chk_kind_e;

  // Expected write-back word and branch flag
  typedef struct packed {
    word_t word;
    logic  branch;
  } ref_t;

  logic        clk;
  logic        rst_n;
  alu_req_t    alu_req;
  md_req_t     md_req;
  logic        md_en;
  logic        lsu_en;
  logic        lsu_ready;
  word_t       alu_adder_result;
  word_t       regfile_wdata;
  word_t       jump_target;
  logic        branch_decision;
  logic        ex_ready;

  // Hand-over between stimulus and compare process
  chk_kind_e   chk_kind;
  logic        pending;
  ref_t        exp_ref;
  word_t       exp_jump;
  logic        chk_jump;
  logic        exp_ready;
  string       test_name;
  string       chk_desc;
  int          wait_cycles;
  int          test_checks;
  int          test_errors;
  int          total_checks;
  int          total_errors;
  logic [31:0] rng_state;
  word_t       corner_vals [5] = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};

  ex_block UUT (
    .clk                ( clk              ),
    .rst_n_i            ( rst_n            ),
    .alu_req_i          ( alu_req          ),
    .md_req_i           ( md_req           ),
    .md_en_i            ( md_en            ),
    .lsu_en_i           ( lsu_en           ),
    .lsu_ready_i        ( lsu_ready        ),
    .alu_adder_result_o ( alu_adder_result ),
    .regfile_wdata_o    ( regfile_wdata    ),
    .jump_target_o      ( jump_target      ),
    .branch_decision_o  ( branch_decision  ),
    .ex_ready_o         ( ex_ready         )
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD/2) clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  task automatic next_rand(output logic [31:0] r);
    rng_state = xorshift32(rng_state);
    r = rng_state;
  endtask

  // Roughly a third of the operands are corner values
  task automatic get_operand(output word_t w);
    logic [31:0] r;
    next_rand(r);
    if (r[3:0] < 4'd5)
      w = corner_vals[r[7:4] % 5];
    else
      next_rand(w);
  endtask

  function automatic ref_t ex_ref(input logic is_md, input alu_req_t a_req,
                                  input md_req_t m_req);
    ref_t        r;
    word_t       a;
    word_t       b;
    logic [63:0] ea;
    logic [63:0] eb;
    logic [63:0] prod;
    logic        sdiv;
    logic        ovf;
    r = '0;
    if (is_md) begin
      a    = m_req.operand_a;
      b    = m_req.operand_b;
      // Sign-extend each operand on its own mode bit
      ea   = m_req.signed_mode[0] ? {{32{a[31]}}, a} : {32'h0, a};
      eb   = m_req.signed_mode[1] ? {{32{b[31]}}, b} : {32'h0, b};
      prod = ea * eb;
      sdiv = (m_req.signed_mode == 2'b11);
      ovf  = sdiv && (a == 32'h8000_0000) && (b == 32'hffff_ffff);
      case (m_req.op)
        MD_MUL:  r.word = prod[31:0];
        MD_MULH: r.word = prod[63:32];
        MD_DIV: begin
          if (b == '0)
            r.word = '1;
          else if (ovf)
            r.word = a;
          else if (sdiv)
            r.word = $signed(a) / $signed(b);
          else
            r.word = a / b;
        end
        default: begin
          if (b == '0)
            r.word = a;
          else if (ovf)
            r.word = '0;
          else if (sdiv)
            r.word = $signed(a) % $signed(b);
          else
            r.word = a % b;
        end
      endcase
    end else begin
      a = a_req.operand_a;
      b = a_req.operand_b;
      case (a_req.op)
        ADD:       r.word = a + b;
        SUB:       r.word = a - b;
        XOR:       r.word = a ^ b;
        OR:        r.word = a | b;
        AND:       r.word = a & b;
        SLL:       r.word = a << b[4:0];
        SRL:       r.word = a >> b[4:0];
        SRA:       r.word = $signed(a) >>> b[4:0];
        SLT, LT:   r.branch = $signed(a) < $signed(b);
        SLTU, LTU: r.branch = a < b;
        EQ:        r.branch = (a == b);
        NE:        r.branch = (a != b);
        GE:        r.branch = $signed(a) >= $signed(b);
        default:   r.branch = a >= b;
      endcase
      // Compare ops write the flag to bit 0
      if (a_req.op inside {SLT, SLTU, EQ, NE, LT, GE, LTU, GEU})
        r.word = word_t'(r.branch);
    end
    return r;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Compare process, samples on the falling edge
  //////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (pending) begin
      if (chk_kind == CHK_LSU) begin
        test_checks++;
        if (ex_ready !== exp_ready) begin
          $display("mismatch %s ex_ready_o: expected %b actual %b",
                   test_name, exp_ready, ex_ready);
          test_errors++;
        end
        pending = 1'b0;
      end else if (ex_ready === 1'b1) begin
        test_checks++;
        if (regfile_wdata !== exp_ref.word) begin
          $display("mismatch %s %s regfile_wdata_o: expected %h actual %h",
                   test_name, chk_desc, exp_ref.word, regfile_wdata);
          test_errors++;
        end
        if (chk_kind == CHK_ALU && branch_decision !== exp_ref.branch) begin
          $display("mismatch %s %s branch_decision_o: expected %b actual %b",
                   test_name, chk_desc, exp_ref.branch, branch_decision);
          test_errors++;
        end
        if (chk_jump && jump_target !== exp_jump) begin
          $display("mismatch %s %s jump_target_o: expected %h actual %h",
                   test_name, chk_desc, exp_jump, jump_target);
          test_errors++;
        end
        if (chk_jump && alu_adder_result !== exp_jump) begin
          $display("mismatch %s %s alu_adder_result_o: expected %h actual %h",
                   test_name, chk_desc, exp_jump, alu_adder_result);
          test_errors++;
        end
        pending = 1'b0;
      end else if (chk_kind == CHK_ALU) begin
        $display("%s %s: ex_ready_o was low for an ALU request", test_name, chk_desc);
        test_checks++;
        test_errors++;
        pending = 1'b0;
      end else begin
        wait_cycles++;
        if (wait_cycles > MD_MAX_WAIT) begin
          $display("%s %s: ex_ready_o did not rise within %0d cycles",
                   test_name, chk_desc, MD_MAX_WAIT);
          test_checks++;
          test_errors++;
          pending = 1'b0;
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  task automatic run_alu(input alu_req_t req, input logic jump_chk);
    @(posedge clk);
    alu_req  <= req;
    md_en    <= 1'b0;
    exp_ref  = ex_ref(1'b0, req, md_req);
    exp_jump = req.operand_a + req.operand_b;
    chk_jump = jump_chk;
    chk_kind = CHK_ALU;
    chk_desc = $sformatf("op %0d a %h b %h", req.op, req.operand_a, req.operand_b);
    pending  = 1'b1;
    wait (!pending);
  endtask

  // Enable stays high, a new request follows the ready cycle
  task automatic run_md(input md_req_t req);
    @(posedge clk);
    md_req      <= req;
    md_en       <= 1'b1;
    exp_ref     = ex_ref(1'b1, alu_req, req);
    chk_jump    = 1'b0;
    chk_kind    = CHK_MD;
    chk_desc    = $sformatf("op %0d mode %b a %h b %h", req.op, req.signed_mode,
                            req.operand_a, req.operand_b);
    wait_cycles = 0;
    pending     = 1'b1;
    wait (!pending);
  endtask

  task automatic run_lsu_cycle();
    logic [31:0] r;
    next_rand(r);
    @(posedge clk);
    lsu_en    <= 1'b1;
    lsu_ready <= r[0];
    exp_ready = r[0];
    chk_kind  = CHK_LSU;
    pending   = 1'b1;
    wait (!pending);
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic end_test();
    $display("test %s: %0d checks, %0d errors", test_name, test_checks, test_errors);
    total_checks += test_checks;
    total_errors += test_errors;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    alu_req_t    areq;
    md_req_t     mreq;
    logic [31:0] r;
    rng_state    = 32'h192c_94e8;
    pending      = 1'b0;
    chk_jump     = 1'b0;
    chk_kind     = CHK_ALU;
    total_checks = 0;
    total_errors = 0;
    rst_n        = 1'b0;
    alu_req      = '0;
    md_req       = '0;
    md_en        = 1'b0;
    lsu_en       = 1'b0;
    lsu_ready    = 1'b0;
    repeat (8) @(posedge clk);
    rst_n <= 1'b1;

    // Random ALU ops over all opcodes
    start_test("alu_random");
    for (int i = 0; i < N_ALU; i++) begin
      next_rand(r);
      areq.op = alu_op_e'(r[3:0]);
      get_operand(areq.operand_a);
      get_operand(areq.operand_b);
      run_alu(areq, 1'b0);
    end
    end_test();

    // Branch compares, jump target on the ADD ones
    start_test("branch");
    for (int i = 0; i < N_BR; i++) begin
      next_rand(r);
      areq.op = (i % 2) ? ADD : alu_op_e'(4'(10 + r % 6));
      get_operand(areq.operand_a);
      get_operand(areq.operand_b);
      run_alu(areq, (i % 2) == 1);
    end
    end_test();

    // All corner pairs then random, each mode, MUL and MULH
    start_test("mul");
    for (int mode = 0; mode < 4; mode++) begin
      for (int i = 0; i < 40; i++) begin
        if (i < 25) begin
          mreq.operand_a = corner_vals[i / 5];
          mreq.operand_b = corner_vals[i % 5];
        end else begin
          get_operand(mreq.operand_a);
          get_operand(mreq.operand_b);
        end
        for (int k = 0; k < 2; k++) begin
          mreq.op          = k ? MD_MULH : MD_MUL;
          mreq.signed_mode = 2'(mode);
          run_md(mreq);
        end
      end
    end
    end_test();

    // Corner pairs hold the zero divisor and the signed overflow case
    start_test("div");
    for (int mode = 0; mode < 2; mode++) begin
      for (int i = 0; i < 45; i++) begin
        if (i < 25) begin
          mreq.operand_a = corner_vals[i / 5];
          mreq.operand_b = corner_vals[i % 5];
        end else begin
          get_operand(mreq.operand_a);
          get_operand(mreq.operand_b);
        end
        for (int k = 0; k < 2; k++) begin
          mreq.op          = k ? MD_REM : MD_DIV;
          mreq.signed_mode = (mode == 0) ? 2'b00 : 2'b11;
          run_md(mreq);
        end
      end
    end
    @(posedge clk);
    md_en <= 1'b0;
    end_test();

    // LSU done level passes straight through
    start_test("lsu");
    for (int i = 0; i < N_LSU; i++) begin
      run_lsu_cycle();
    end
    @(posedge clk);
    lsu_en <= 1'b0;
    end_test();

    $display("total: %0d checks, %0d errors", total_checks, total_errors);
    if (total_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  // Generous bound, every request gets a full multiply/divide budget
  initial begin
    #(N_REQ * (`EX_MD_STEPS + 8) * CLK_PERIOD);
    $display("Timeout in test %s: ready never came", test_name);
    $display("Simulation failed");
    $finish;
  end

endmodule

//--- filelist.f
+incdir+src
src/ex_pkg.sv
src/ex_alu.sv
src/ex_md_ctrl.sv
src/ex_md_datapath.sv
src/ex_block.sv
testbench/ex_block_assertions.sv
testbench/ex_block_tb.sv
